/* tb_rx_dma_input.txt */
# kind count gap ready dropped  (kind G good, B bad; gap in idle cycles after the end pulse)
# ready 0 always high, 1 random, 2 low until the frame ends; dropped 1 if the frame overflows
G 4 3 0 0
G 20 2 0 0
B 6 2 0 0
G 16 5 1 0
G 3 40 1 0
B 10 1 1 0
G 33 3 1 0
G 1 250 0 0
G 40 1 2 0
G 30 4 2 1
G 8 10 0 0
B 12 2 0 0
G 17 5 1 0

/* rx_dma.f */
mac_rx_pkg.sv
tlp_pkg.sv
mac_rx_interface.sv
rx_ring_buffer.sv
tlp_trigger.sv
tlp_sender.sv
rx_dma_top.sv
tb_rx_dma.sv

/* run.sh */
#!/bin/sh
rm -f sim.log
verilator --binary --timing --assert --top-module tb_rx_dma -f rx_dma.f -o sim_rx_dma \
    && ./obj_dir/sim_rx_dma 2>&1 | tee sim.log
grep -q "^NO ERRORS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

/* tb_rx_dma.sv */
`default_nettype none

module tb_rx_dma import mac_rx_pkg::*;;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_BURST    = 16;                   // DUT defaults
    localparam int FLUSH_CYCLES = 32;

    logic        clk;
    logic        reset_n;
    qword_t      rx_data;
    byte_mask_t  rx_data_valid;
    logic        rx_good_frame;
    logic        rx_bad_frame;
    qword_t      tlp_data;
    logic        tlp_valid;
    logic        tlp_last;
    logic        tlp_ready;
    logic [31:0] good_frame_count;
    logic [31:0] bad_frame_count;
    logic [31:0] dropped_frame_count;

    byte    kind_q[$];                                  // One entry per frame line
    int     count_q[$];
    int     gap_q[$];
    int     mode_q[$];
    qword_t exp_q[$];                                   // Good frames in output order
    int     exp_good, exp_bad, exp_drop;
    int     timeout_limit, cycle_count, burst_words;
    logic   prev_stall, prev_last;
    qword_t prev_data;
    logic [15:0] lfsr;

    rx_dma_top u_rx_dma_top (
        .xaui_clk_156_25_out(clk), .reset_n(reset_n),
        .rx_data(rx_data), .rx_data_valid(rx_data_valid),
        .rx_good_frame(rx_good_frame), .rx_bad_frame(rx_bad_frame),
        .tlp_data(tlp_data), .tlp_valid(tlp_valid), .tlp_last(tlp_last),
        .tlp_ready(tlp_ready), .good_frame_count(good_frame_count),
        .bad_frame_count(bad_frame_count), .dropped_frame_count(dropped_frame_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;                          // 8 ns period
    end

    // --------------------------------------------------
    // Helpers
    // --------------------------------------------------
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);    // Galois, taps 16 14 13 11
    endfunction

    task automatic stop_run();
        $display("ERRORS FOUND");
        $fatal(1, "Simulation stopped on failure");
    endtask

    task automatic check_value(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic set_ready(input int mode, input logic in_frame);
        if (mode == 1) begin
            lfsr      = lfsr_next(lfsr);                // One step per ready bit
            tlp_ready = lfsr[0];
        end else begin
            tlp_ready = !(mode == 2 && in_frame);       // Mode 2 stalls only during the frame
        end
    endtask

    task automatic read_frames();
        int    fd, code, n, gap, mode, drop, f;
        string line;
        byte   kind;
        fd = $fopen("tb_rx_dma_input.txt", "r");
        if (fd == 0) begin
            $display("Could not open the input file tb_rx_dma_input.txt");
            stop_run();
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line[0] == "#") continue;         // Comment or blank
            code = $sscanf(line, "%c %d %d %d %d", kind, n, gap, mode, drop);
            if (code != 5) begin
                $display("Malformed line in the input file: %s", line);
                stop_run();
            end
            f = kind_q.size();                                      // Frame number
            kind_q.push_back(kind);
            count_q.push_back(n);
            gap_q.push_back(gap);
            mode_q.push_back(mode);
            timeout_limit += n + gap;
            if (drop != 0) exp_drop++;
            else if (kind == "B") exp_bad++;
            else begin
                exp_good++;
                for (int k = 0; k < n; k++) exp_q.push_back({f[31:0], k[31:0]});
            end
        end
        $fclose(fd);
        timeout_limit = 10 * timeout_limit + 500;
    endtask

    task automatic drive_frame(input int f, input byte kind, input int n, input int gap,
                               input int mode);
        for (int k = 0; k < n; k++) begin
            rx_data       = {f[31:0], k[31:0]};         // Frame in upper half, index in lower
            rx_data_valid = (k == n - 1) ? 8'h0F : 8'hFF;
            set_ready(mode, 1'b1);
            @(negedge clk);
        end
        rx_data_valid = '0;
        rx_good_frame = (kind == "G");                  // End pulse one cycle after last word
        rx_bad_frame  = (kind == "B");
        set_ready(mode, 1'b1);
        @(negedge clk);
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        repeat (gap) begin
            set_ready(mode, 1'b0);
            @(negedge clk);
        end
    endtask

    // --------------------------------------------------
    // Output monitor and timeout
    // --------------------------------------------------
    always @(posedge clk) begin
        cycle_count++;
        if (timeout_limit != 0 && cycle_count > timeout_limit) begin
            $display("Timeout after %0d cycles, output never drained", cycle_count);
            stop_run();
        end
        if (reset_n) begin
            if (prev_stall) begin                       // Stalled word must hold
                check_value(64'(tlp_valid), 64'd1, "valid dropped while stalled");
                check_value(tlp_data, prev_data, "data moved while stalled");
                check_value(64'(tlp_last), 64'(prev_last), "last moved while stalled");
            end
            if (tlp_valid && tlp_ready) begin
                if (exp_q.size() == 0) begin
                    $display("Output word %h arrived with no word expected", tlp_data);
                    stop_run();
                end
                check_value(tlp_data, exp_q.pop_front(), "output word");
                burst_words++;
                check_value(64'(burst_words <= MAX_BURST), 64'd1, "burst too long");
                if (tlp_last) burst_words = 0;          // Burst closed
            end
            prev_stall = tlp_valid && !tlp_ready;
            prev_data  = tlp_data;
            prev_last  = tlp_last;
        end
    end

    // --------------------------------------------------
    // Main sequence
    // --------------------------------------------------
    initial begin
        reset_n       = 1'b0;
        rx_data       = '0;
        rx_data_valid = '0;
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        tlp_ready     = 1'b1;
        lfsr          = 16'd62;                         // Seed
        {exp_good, exp_bad, exp_drop, timeout_limit} = '0;
        {cycle_count, burst_words} = '0;
        prev_stall    = 1'b0;
        prev_last     = 1'b0;
        prev_data     = '0;
        read_frames();
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;
        for (int f = 0; f < kind_q.size(); f++) begin
            drive_frame(f, kind_q[f], count_q[f], gap_q[f], mode_q[f]);
        end
        tlp_ready = 1'b1;
        while (exp_q.size() != 0) @(negedge clk);      // Timeout guards this wait
        repeat (FLUSH_CYCLES + MAX_BURST) @(negedge clk);   // Catch stray words
        check_value(64'(burst_words), 64'd0, "burst left without last");
        check_value(64'(good_frame_count), 64'(exp_good), "good frame count");
        check_value(64'(bad_frame_count), 64'(exp_bad), "bad frame count");
        check_value(64'(dropped_frame_count), 64'(exp_drop), "dropped frame count");
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

/* rx_dma_top.sv */
`default_nettype none

module rx_dma_top import mac_rx_pkg::*, tlp_pkg::*; #(
    parameter int BUF_ADDR_W   = 6,                     // 64 qwords
    parameter int MAX_BURST    = 16,
    parameter int FLUSH_CYCLES = 32
) (
    input  wire logic        xaui_clk_156_25_out,
    input  wire logic        reset_n,
    input  wire qword_t      rx_data,                   // MAC receive bus
    input  wire byte_mask_t  rx_data_valid,
    input  wire logic        rx_good_frame,
    input  wire logic        rx_bad_frame,
    output qword_t           tlp_data,                  // Burst output
    output logic             tlp_valid,
    output logic             tlp_last,
    input  wire logic        tlp_ready,
    output logic [31:0]      good_frame_count,
    output logic [31:0]      bad_frame_count,
    output logic [31:0]      dropped_frame_count
);

    // --------------------------------------------------
    // Internal links
    // --------------------------------------------------
    logic                  wr_en;
    logic [BUF_ADDR_W-1:0] wr_addr;
    qword_t                wr_data;
    logic                  rd_en;
    logic [BUF_ADDR_W-1:0] rd_addr;
    qword_t                rd_data;
    logic [BUF_ADDR_W:0]   committed_wr_address;        // Receive side to trigger
    logic [BUF_ADDR_W:0]   committed_rd_address;        // Sender to trigger and receive side
    logic                  trigger_tlp;
    logic                  trigger_tlp_ack;
    burst_len_t            qwords_to_send;

    mac_rx_interface #(.BUF_ADDR_W(BUF_ADDR_W)) u_mac_rx_interface (
        .xaui_clk_156_25_out(xaui_clk_156_25_out), .reset_n(reset_n),
        .rx_data(rx_data), .rx_data_valid(rx_data_valid),
        .rx_good_frame(rx_good_frame), .rx_bad_frame(rx_bad_frame),
        .committed_rd_address(committed_rd_address),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .committed_wr_address(committed_wr_address),
        .good_frame_count(good_frame_count), .bad_frame_count(bad_frame_count),
        .dropped_frame_count(dropped_frame_count)
    );

    rx_ring_buffer #(.BUF_ADDR_W(BUF_ADDR_W)) u_rx_ring_buffer (
        .xaui_clk_156_25_out(xaui_clk_156_25_out),
        .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
        .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data)
    );

    tlp_trigger #(
        .BUF_ADDR_W(BUF_ADDR_W), .MAX_BURST(MAX_BURST), .FLUSH_CYCLES(FLUSH_CYCLES)
    ) u_tlp_trigger (
        .xaui_clk_156_25_out(xaui_clk_156_25_out), .reset_n(reset_n),
        .committed_wr_address(committed_wr_address),
        .committed_rd_address(committed_rd_address),
        .trigger_tlp_ack(trigger_tlp_ack), .trigger_tlp(trigger_tlp),
        .qwords_to_send(qwords_to_send)
    );

    tlp_sender #(.BUF_ADDR_W(BUF_ADDR_W)) u_tlp_sender (
        .xaui_clk_156_25_out(xaui_clk_156_25_out), .reset_n(reset_n),
        .trigger_tlp(trigger_tlp), .qwords_to_send(qwords_to_send),
        .rd_data(rd_data), .tlp_ready(tlp_ready),
        .rd_en(rd_en), .rd_addr(rd_addr),
        .committed_rd_address(committed_rd_address), .trigger_tlp_ack(trigger_tlp_ack),
        .tlp_data(tlp_data), .tlp_valid(tlp_valid), .tlp_last(tlp_last)
    );

endmodule

`default_nettype wire

/* tlp_sender.sv */
`default_nettype none

module tlp_sender import mac_rx_pkg::*, tlp_pkg::*; #(
    parameter int BUF_ADDR_W = 6                        // Buffer address width
) (
    input  wire logic                  xaui_clk_156_25_out,
    input  wire logic                  reset_n,
    input  wire logic                  trigger_tlp,
    input  wire burst_len_t            qwords_to_send,
    input  wire qword_t                rd_data,
    input  wire logic                  tlp_ready,
    output logic                       rd_en,
    output logic [BUF_ADDR_W-1:0]      rd_addr,
    output logic [BUF_ADDR_W:0]        committed_rd_address,
    output logic                       trigger_tlp_ack,
    output qword_t                     tlp_data,
    output logic                       tlp_valid,
    output logic                       tlp_last
);

    localparam int PTR_W = BUF_ADDR_W + 1;

    send_state_e      state;
    burst_len_t       burst_len;                        // Latched request size
    burst_len_t       sent_cnt;                         // Words accepted so far
    logic [PTR_W-1:0] rd_ptr;                           // Next word to fetch
    logic             accept;

    // --------------------------------------------------
    // Output port and read-ahead
    // --------------------------------------------------
    assign tlp_valid = (state == SEND_DATA);
    assign tlp_last  = tlp_valid && (sent_cnt == burst_len - 8'd1);
    assign tlp_data  = rd_data;                         // Held by the RAM while stalled
    assign accept    = tlp_valid && tlp_ready;
    assign rd_en     = (state == SEND_READ) || (accept && !tlp_last);   // Refill on accept
    assign rd_addr   = rd_ptr[BUF_ADDR_W-1:0];

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state                <= SEND_IDLE;
            burst_len            <= '0;
            sent_cnt             <= '0;
            rd_ptr               <= '0;
            committed_rd_address <= '0;
            trigger_tlp_ack      <= 1'b0;
        end else begin
            trigger_tlp_ack <= 1'b0;                                    // One-cycle pulse
            if (rd_en) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case (state)
                SEND_IDLE: begin
                    if (trigger_tlp && !trigger_tlp_ack) begin          // Skip the old request
                        burst_len <= qwords_to_send;
                        sent_cnt  <= '0;
                        state     <= SEND_READ;
                    end
                end
                SEND_READ: state <= SEND_DATA;                          // First word in RAM reg
                SEND_DATA: begin
                    if (accept) begin
                        sent_cnt <= sent_cnt + 8'd1;
                        if (tlp_last) begin
                            committed_rd_address <= committed_rd_address + PTR_W'(burst_len);
                            trigger_tlp_ack      <= 1'b1;               // Same edge as pointer
                            state                <= SEND_IDLE;
                        end
                    end
                end
                default: state <= SEND_IDLE;
            endcase
        end
    end

    // Stalled word and its last flag hold until taken
    a_stall_hold: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        tlp_valid && !tlp_ready |=> tlp_valid && $stable(tlp_data) && $stable(tlp_last));

endmodule

`default_nettype wire

/* tlp_trigger.sv */
`default_nettype none

module tlp_trigger import tlp_pkg::*; #(
    parameter int BUF_ADDR_W   = 6,                     // Pointer width is one more
    parameter int MAX_BURST    = 16,                    // Largest burst in qwords
    parameter int FLUSH_CYCLES = 32                     // Idle cycles before a partial flush
) (
    input  wire logic                  xaui_clk_156_25_out,
    input  wire logic                  reset_n,
    input  wire logic [BUF_ADDR_W:0]   committed_wr_address,
    input  wire logic [BUF_ADDR_W:0]   committed_rd_address,
    input  wire logic                  trigger_tlp_ack,
    output logic                       trigger_tlp,
    output burst_len_t                 qwords_to_send
);

    localparam int PTR_W   = BUF_ADDR_W + 1;
    localparam int FLUSH_W = $clog2(FLUSH_CYCLES + 1);

    trig_state_e        state;
    logic [PTR_W-1:0]   pending;                        // Committed but not yet sent
    logic [PTR_W-1:0]   last_wr_address;                // Commit edge detect
    logic [FLUSH_W-1:0] flush_cnt;
    logic               commit_seen;
    logic               size_hit;
    logic               flush_hit;

    // --------------------------------------------------
    // Burst conditions
    // --------------------------------------------------
    assign pending     = committed_wr_address - committed_rd_address;     // Modulo 2*depth
    assign commit_seen = (committed_wr_address != last_wr_address);      // New frame landed
    assign size_hit    = (int'(pending) >= MAX_BURST);                    // Full burst ready
    assign flush_hit   = (pending != '0) && !commit_seen &&
                         (flush_cnt == FLUSH_W'(FLUSH_CYCLES - 1));       // Quiet too long

    // --------------------------------------------------
    // Request FSM
    // --------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state           <= TRIG_IDLE;
            trigger_tlp     <= 1'b0;
            qwords_to_send  <= '0;
            flush_cnt       <= '0;
            last_wr_address <= '0;
        end else begin
            last_wr_address <= committed_wr_address;
            case (state)
                TRIG_IDLE: begin
                    if (size_hit || flush_hit) begin
                        trigger_tlp    <= 1'b1;                           // Held until ack
                        qwords_to_send <= size_hit ? burst_len_t'(MAX_BURST)
                                                   : burst_len_t'(pending); // Smaller of two
                        flush_cnt      <= '0;
                        state          <= TRIG_WAIT_ACK;
                    end else if ((pending == '0) || commit_seen) begin
                        flush_cnt <= '0;                                  // Restart timeout
                    end else begin
                        flush_cnt <= flush_cnt + FLUSH_W'(1);
                    end
                end
                TRIG_WAIT_ACK: begin
                    if (trigger_tlp_ack) begin                            // Read pointer moved
                        trigger_tlp <= 1'b0;
                        state       <= TRIG_IDLE;
                    end
                end
                default: state <= TRIG_IDLE;
            endcase
        end
    end

    // Requested size is always a legal burst
    a_burst_len: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp |-> (qwords_to_send != '0) && (int'(qwords_to_send) <= MAX_BURST));

endmodule

`default_nettype wire

/* rx_ring_buffer.sv */
`default_nettype none

module rx_ring_buffer import mac_rx_pkg::*; #(
    parameter int BUF_ADDR_W = 6                        // Address width of the qword store
) (
    input  wire logic                  xaui_clk_156_25_out,
    input  wire logic                  wr_en,
    input  wire logic [BUF_ADDR_W-1:0] wr_addr,
    input  wire qword_t                wr_data,
    input  wire logic                  rd_en,
    input  wire logic [BUF_ADDR_W-1:0] rd_addr,
    output qword_t                     rd_data
);

    localparam int DEPTH = 2 ** BUF_ADDR_W;

    qword_t mem [DEPTH];                                // Simple dual port, one clock

    // --------------------------------------------------
    // Write side
    // --------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;                    // Receive words, committed or not
        end
    end

    // --------------------------------------------------
    // Read side, registered output
    // --------------------------------------------------
    // Reads only touch committed words, so the write port never hits the
    // same address in the same cycle
    always_ff @(posedge xaui_clk_156_25_out) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];                    // Valid one cycle after rd_en
        end
    end

endmodule

`default_nettype wire

/* mac_rx_interface.sv */
`default_nettype none

module mac_rx_interface import mac_rx_pkg::*; #(
    parameter int BUF_ADDR_W = 6                        // Buffer holds 2**BUF_ADDR_W qwords
) (
    input  wire logic                  xaui_clk_156_25_out,
    input  wire logic                  reset_n,
    input  wire qword_t                rx_data,
    input  wire byte_mask_t            rx_data_valid,
    input  wire logic                  rx_good_frame,
    input  wire logic                  rx_bad_frame,
    input  wire logic [BUF_ADDR_W:0]   committed_rd_address,
    output logic                       wr_en,
    output logic [BUF_ADDR_W-1:0]      wr_addr,
    output qword_t                     wr_data,
    output logic [BUF_ADDR_W:0]        committed_wr_address,
    output logic [31:0]                good_frame_count,
    output logic [31:0]                bad_frame_count,
    output logic [31:0]                dropped_frame_count
);

    localparam int PTR_W = BUF_ADDR_W + 1;              // Extra bit tells full from empty
    localparam int DEPTH = 2 ** BUF_ADDR_W;

    rx_state_e        state;
    logic [PTR_W-1:0] wr_ptr;                           // Runs ahead of the committed pointer
    logic             word_in;
    logic             full_next;

    // --------------------------------------------------
    // Write port, word lands on the next edge
    // --------------------------------------------------
    assign word_in   = (rx_data_valid != '0);           // Any lane valid
    assign full_next = ((wr_ptr + PTR_W'(1) - committed_rd_address) == PTR_W'(DEPTH));

    assign wr_en   = word_in && (state != RX_DROP) && !full_next;
    assign wr_addr = wr_ptr[BUF_ADDR_W-1:0];            // Wraps with the ring
    assign wr_data = rx_data;                           // Partial last word stored as is

    // --------------------------------------------------
    // Frame FSM, commit and rewind
    // --------------------------------------------------
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state                <= RX_IDLE;
            wr_ptr               <= '0;
            committed_wr_address <= '0;
            good_frame_count     <= '0;
            bad_frame_count      <= '0;
            dropped_frame_count  <= '0;
        end else if (rx_good_frame || rx_bad_frame) begin
            state <= RX_IDLE;                                       // End pulse closes frame
            if (state == RX_DROP) begin
                wr_ptr              <= committed_wr_address;        // Discard partial frame
                dropped_frame_count <= dropped_frame_count + 32'd1; // Even if MAC says good
            end else if (rx_good_frame) begin
                committed_wr_address <= wr_ptr;                     // Frame visible to trigger
                good_frame_count     <= good_frame_count + 32'd1;
            end else begin
                wr_ptr          <= committed_wr_address;            // Rewind bad frame
                bad_frame_count <= bad_frame_count + 32'd1;
            end
        end else if (word_in && (state != RX_DROP)) begin
            if (full_next) begin
                state <= RX_DROP;                                   // No room, stop writing
            end else begin
                wr_ptr <= wr_ptr + PTR_W'(1);
                state  <= RX_FRAME;
            end
        end
    end

    // MAC never flags both endings at once
    a_end_onehot: assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        !(rx_good_frame && rx_bad_frame));

endmodule

`default_nettype wire

/* tlp_pkg.sv */
`default_nettype none

// --------------------------------------------------
// Burst side types
// --------------------------------------------------
package tlp_pkg;

    // Qword count of one burst, 1 to 255
    typedef logic [7:0] burst_len_t;

    // Trigger FSM, request held until ack
    typedef enum logic {
        TRIG_IDLE     = 1'b0,             // Watching pending count and flush timer
        TRIG_WAIT_ACK = 1'b1              // Request out, waiting for sender
    } trig_state_e;

    // Sender FSM
    typedef enum logic [1:0] {
        SEND_IDLE = 2'd0,                 // No burst in flight
        SEND_READ = 2'd1,                 // First buffer read issued
        SEND_DATA = 2'd2                  // Words on the output port
    } send_state_e;

endpackage

`default_nettype wire

/* mac_rx_pkg.sv */
`default_nettype none

// --------------------------------------------------
// MAC receive side types
// --------------------------------------------------
package mac_rx_pkg;

    // One word of the 64-bit MAC receive bus
    typedef logic [63:0] qword_t;         // Lane 0 in the low byte

    // Byte lane valid flags, one bit per lane
    typedef logic [7:0] byte_mask_t;      // 8'hFF on full words

    // Receive FSM states
    typedef enum logic [1:0] {
        RX_IDLE  = 2'd0,                  // Between frames, pointer committed
        RX_FRAME = 2'd1,                  // Frame in progress, writing words
        RX_DROP  = 2'd2                   // Buffer full, rest of frame discarded
    } rx_state_e;

endpackage

`default_nettype wire
